// File: build.f
+incdir+rtl
rtl/pu_pkg.sv
rtl/rr_arbiter.sv
rtl/sel_fifo.sv
rtl/pio_mem.sv
rtl/pu_switch_info_mem.sv
testbench/tb_clock_gen.sv
testbench/tb_pu_switch_info_mem.sv

// File: rtl/pio_mem.sv
// single-port switch-info table shared by the host register port and one application read port
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pio_mem import pu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,

	// host register port
	input wire pio_word_t reg_addr,
	input wire pio_word_t reg_din,
	input wire logic reg_rd,
	input wire logic reg_wr,
	input wire logic reg_ms,

	output logic mem_ack,
	output pio_word_t mem_rdata,

	// application read port
	input wire logic app_rd,
	input wire row_addr_t app_raddr,

	output logic app_ready,
	output logic app_ack,
	output switch_info_t app_rdata
);

	localparam int DEPTH = 1 << `SWITCH_INFO_DEPTH_NBITS;

	switch_info_t mem [DEPTH]; // table storage behind one port

	logic host_rd;
	logic host_wr;
	logic host_strobe; // host owns the port this cycle

	logic hold_valid; // an app read lost the port and waits
	row_addr_t hold_addr;

	logic app_pend; // an app read wants the port
	row_addr_t app_addr;
	row_addr_t port_addr;
	switch_info_t port_q; // registered read word for either side

	assign host_rd = reg_ms & reg_rd;
	assign host_wr = reg_ms & reg_wr;
	assign host_strobe = host_rd | host_wr;

	// the held read goes first since no new read is granted while one waits
	assign app_pend = app_rd | hold_valid;
	assign app_addr = hold_valid ? hold_addr : app_raddr;

	assign port_addr = host_strobe ?
		row_addr_t'(reg_addr[`SWITCH_INFO_DEPTH_NBITS-1:0]) : app_addr;

	// ready also drops in the cycle a read gets blocked, because the arbiter looks one cycle ahead
	assign app_ready = ~hold_valid & ~(app_rd & host_strobe);

	// the single port reads old data when it writes
	always_ff @(posedge clk) begin
		if (host_wr) begin
			mem[port_addr] <= switch_info_t'(reg_din);
		end
		port_q <= mem[port_addr];
	end

	assign mem_rdata = pio_word_t'(port_q);
	assign app_rdata = port_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_ack <= 1'b0;
			app_ack <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			mem_ack <= host_strobe;
			app_ack <= app_pend & ~host_strobe;
			hold_valid <= app_pend & host_strobe; // blocked reads stay held until the port frees
		end
	end

	// a held address is simply recaptured while the host keeps the port
	always_ff @(posedge clk) begin
		if (host_strobe) begin
			hold_addr <= app_addr;
		end
	end

	a_one_host_strobe: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(reg_rd && reg_wr)
	) else $error("pio_mem: reg_rd and reg_wr high together");

	// the arbiter must respect app_ready or a second blocked read would be lost
	a_single_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		app_rd |-> !hold_valid
	) else $error("pio_mem: app read arrived while another one is held");

endmodule

`default_nettype wire

// File: rtl/pu_defines.svh
// switch-info table parameters shared by the PU request path and the host register port
`ifndef PU_DEFINES_SVH
`define PU_DEFINES_SVH

// processing units that share the table
`define NUM_OF_PU 4
`define PU_ID_NBITS 2

// host register port
`define PIO_NBITS 32

// table word and row geometry
`define SWITCH_INFO_NBITS 32
`define FID_NBITS 2
`define ROW_LOW_NBITS 4

// the row is the flow id on top of the low address bits
`define SWITCH_INFO_DEPTH_NBITS (`FID_NBITS + `ROW_LOW_NBITS)

// PU I/O address and its region decode
`define IO_ADDR_NBITS 16
`define REGION_NBITS 4

// region code that selects the switch-info table
`define REGION_SWITCH_INFO 4'h3

`endif

// File: rtl/pu_pkg.sv
// switch-info package with the vector types shared by the table, its arbiter and the PU port
`default_nettype none

`include "pu_defines.svh"

package pu_pkg;

	// index of one processing unit
	typedef logic [`PU_ID_NBITS-1:0] pu_id_t;

	// host register address or data
	typedef logic [`PIO_NBITS-1:0] pio_word_t;

	// one word of the switch-info table
	typedef logic [`SWITCH_INFO_NBITS-1:0] switch_info_t;

	// flow id carried with each PU request
	typedef logic [`FID_NBITS-1:0] fid_t;

	// PU I/O address, region code in the top bits
	typedef logic [`IO_ADDR_NBITS-1:0] io_addr_t;

	// table row made of flow id and low address bits
	typedef logic [`SWITCH_INFO_DEPTH_NBITS-1:0] row_addr_t;

endpackage

`default_nettype wire

// File: rtl/pu_switch_info_mem.sv
// switch-info table top that filters PU reads, arbitrates them and returns each acknowledge to its PU
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_switch_info_mem import pu_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,

	// host register port
	input wire pio_word_t reg_addr,
	input wire pio_word_t reg_din,
	input wire logic reg_rd,
	input wire logic reg_wr,
	input wire logic reg_ms_switch_info,

	output logic switch_info_mem_ack,
	output pio_word_t switch_info_mem_rdata,

	// PU read requests and acknowledges
	input wire logic [`NUM_OF_PU-1:0] io_req,
	input wire io_addr_t io_addr [`NUM_OF_PU],
	input wire fid_t io_fid [`NUM_OF_PU],

	output logic [`NUM_OF_PU-1:0] io_ack,
	output switch_info_t io_ack_data [`NUM_OF_PU]
);

	logic [`NUM_OF_PU-1:0] accept; // request hits the switch-info region
	logic [`NUM_OF_PU-1:0] pending; // accepted and not yet granted
	logic [`NUM_OF_PU-1:0] clear; // granted this cycle
	logic [`NUM_OF_PU-1:0] arb_req;
	logic [`NUM_OF_PU-1:0] ack_hit;

	fid_t cmd_fid [`NUM_OF_PU];
	logic [`ROW_LOW_NBITS-1:0] cmd_low [`NUM_OF_PU];

	logic arb_en;
	logic arb_gnt;
	pu_id_t arb_sel;

	logic fifo_full;
	pu_id_t fifo_head; // PU that owns the next memory answer

	row_addr_t app_raddr;
	logic app_ready;
	logic app_ack;
	switch_info_t app_rdata;

	always_comb begin
		for (int i = 0; i < `NUM_OF_PU; i++) begin
			accept[i] = io_req[i] &
				(io_addr[i][`IO_ADDR_NBITS-1 -: `REGION_NBITS] == `REGION_SWITCH_INFO);
			clear[i] = arb_gnt & (arb_sel == pu_id_t'(i));
			ack_hit[i] = app_ack & (fifo_head == pu_id_t'(i));
		end
	end

	// a PU being granted right now must not be offered to the arbiter again
	assign arb_req = pending & ~clear;
	assign arb_en = ~fifo_full & app_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < `NUM_OF_PU; i++) begin
				if (accept[i]) begin
					pending[i] <= 1'b1;
				end else if (clear[i]) begin
					pending[i] <= 1'b0;
				end
			end
		end
	end

	// only the fields that form the row are kept
	always_ff @(posedge clk) begin
		for (int i = 0; i < `NUM_OF_PU; i++) begin
			if (accept[i]) begin
				cmd_fid[i] <= io_fid[i];
				cmd_low[i] <= io_addr[i][`ROW_LOW_NBITS-1:0];
			end
		end
	end

	assign app_raddr = {cmd_fid[arb_sel], cmd_low[arb_sel]};

	rr_arbiter #(.N(`NUM_OF_PU)) u_rr_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.en(arb_en),
		.req(arb_req),
		.sel(arb_sel),
		.gnt(arb_gnt)
	);

	sel_fifo #(.DEPTH(2)) u_sel_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(arb_gnt),
		.din(arb_sel),
		.rd(app_ack),
		.dout(fifo_head),
		.full(fifo_full),
		.empty()
	);

	pio_mem u_pio_mem (
		.clk(clk),
		.rst_n(rst_n),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms(reg_ms_switch_info),
		.mem_ack(switch_info_mem_ack),
		.mem_rdata(switch_info_mem_rdata),
		.app_rd(arb_gnt),
		.app_raddr(app_raddr),
		.app_ready(app_ready),
		.app_ack(app_ack),
		.app_rdata(app_rdata)
	);

	// data toward a PU is zero outside its ack cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			io_ack <= '0;
			for (int i = 0; i < `NUM_OF_PU; i++) begin
				io_ack_data[i] <= '0;
			end
		end else begin
			io_ack <= ack_hit;
			for (int i = 0; i < `NUM_OF_PU; i++) begin
				io_ack_data[i] <= ack_hit[i] ? app_rdata : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rr_arbiter.sv
// round-robin arbiter that registers a one-cycle grant for the next requester after the last winner
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module rr_arbiter import pu_pkg::*; #(
	parameter int N = `NUM_OF_PU
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic en,
	input wire logic [N-1:0] req,

	output pu_id_t sel,
	output logic gnt
);

	pu_id_t win; // requester that would win this cycle
	logic found; // some requester was seen

	// search starts one past the last winner and wraps around
	always_comb begin
		int idx;
		idx = 0;
		win = sel;
		found = 1'b0;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(sel) + k) % N;
			if (!found && req[idx]) begin
				win = pu_id_t'(idx);
				found = 1'b1;
			end
		end
	end

	// sel keeps the last winner between grants and so doubles as the pointer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			gnt <= 1'b0;
			sel <= pu_id_t'(N - 1); // first search begins at requester 0
		end else begin
			gnt <= en & found;
			if (en && found) begin
				sel <= win;
			end
		end
	end

	// a grant must name a requester that was asking in the cycle before
	a_gnt_had_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		gnt |-> |($past(req) & (N'(1) << sel))
	) else $error("rr_arbiter: grant to %0d without a request", sel);

endmodule

`default_nettype wire

// File: rtl/sel_fifo.sv
// small FIFO of granted PU ids whose head is visible before it is popped
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module sel_fifo import pu_pkg::*; #(
	parameter int DEPTH = 2
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wr,
	input wire pu_id_t din,

	input wire logic rd,
	output pu_id_t dout,

	output logic full,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH) + 1;

	pu_id_t store [DEPTH]; // ids in grant order
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign dout = store[rd_ptr]; // head is shown without a read
	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (wr) begin
			store[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither leave the level alone
			endcase
		end
	end

	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr |-> !full
	) else $error("sel_fifo: write while full");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd |-> !empty
	) else $error("sel_fifo: read while empty");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the switch-info table testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

TOP=tb_pu_switch_info_mem
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module "$TOP" \
	-Mdir obj_dir

./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: testbench/tb_clock_gen.sv
// clock and reset source for the testbench, 20 ns period with reset held for five cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk); // low for five rising edges
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_pu_switch_info_mem.sv
// testbench for the shared switch-info table with host register traffic and PU reads
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module tb_pu_switch_info_mem import pu_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 200;
	localparam int LATENCY = 4; // io_req cycle to io_ack with an idle host
	localparam int ROWS = 1 << `SWITCH_INFO_DEPTH_NBITS;

	typedef enum logic [1:0] {STEP_PU, STEP_HOST_WR, STEP_HOST_RD} step_kind_t;

	typedef struct packed {
		step_kind_t kind;
		logic [`NUM_OF_PU-1:0] mask; // PUs that request in this step
		io_addr_t addr; // PU address, or the table row for a host strobe
		fid_t fid;
		logic exact; // the ack latency must be exactly LATENCY
		logic [7:0] gap; // idle cycles after the step
		logic sync; // wait for all PU acks before the next step
	} step_t;

	logic clk;
	logic rst_n;
	pio_word_t reg_addr;
	pio_word_t reg_din;
	logic reg_rd;
	logic reg_wr;
	logic reg_ms_switch_info;
	logic switch_info_mem_ack;
	pio_word_t switch_info_mem_rdata;
	logic [`NUM_OF_PU-1:0] io_req;
	io_addr_t io_addr [`NUM_OF_PU];
	fid_t io_fid [`NUM_OF_PU];
	logic [`NUM_OF_PU-1:0] io_ack;
	switch_info_t io_ack_data [`NUM_OF_PU];

	logic [31:0] lcg_state;
	switch_info_t model [ROWS]; // what the table should hold
	step_t steps [$];
	logic [`NUM_OF_PU-1:0] outstanding; // PUs still owed an ack
	switch_info_t exp_data [`NUM_OF_PU];
	int req_cycle [`NUM_OF_PU];
	logic [`NUM_OF_PU-1:0] exact_lat;
	pu_id_t last_winner;
	logic host_due; // a host strobe was driven on the previous falling edge
	logic host_due_rd;
	switch_info_t host_exp;
	int cycle;

	tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	pu_switch_info_mem dut_i (
		.clk(clk), .rst_n(rst_n),
		.reg_addr(reg_addr), .reg_din(reg_din), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_ms_switch_info(reg_ms_switch_info),
		.switch_info_mem_ack(switch_info_mem_ack), .switch_info_mem_rdata(switch_info_mem_rdata),
		.io_req(io_req), .io_addr(io_addr), .io_fid(io_fid),
		.io_ack(io_ack), .io_ack_data(io_ack_data)
	);

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// first outstanding PU after the last one acknowledged
	function automatic pu_id_t next_rr_pu();
		pu_id_t p;
		logic found;
		p = last_winner;
		found = 1'b0;
		for (int k = 1; k <= `NUM_OF_PU; k++) begin
			if (!found && outstanding[(int'(last_winner) + k) % `NUM_OF_PU]) begin
				p = pu_id_t'((int'(last_winner) + k) % `NUM_OF_PU);
				found = 1'b1;
			end
		end
		return p;
	endfunction

	// one falling edge: check every output, then return the inputs to idle
	task automatic tick();
		pu_id_t want;
		logic [`NUM_OF_PU-1:0] want_ack;
		logic due;
		@(negedge clk);
		cycle++;
		assert (switch_info_mem_ack == host_due) else stop_on_error($sformatf(
			"FAILED t=%0t switch_info_mem_ack: got %b expected %b",
			$time, switch_info_mem_ack, host_due));
		if (host_due_rd) begin
			assert (switch_info_mem_rdata == pio_word_t'(host_exp)) else stop_on_error($sformatf(
				"FAILED t=%0t switch_info_mem_rdata: got %h expected %h",
				$time, switch_info_mem_rdata, host_exp));
		end
		host_due = 1'b0;
		host_due_rd = 1'b0;
		want = next_rr_pu();
		want_ack = '0;
		if (outstanding != '0) begin
			want_ack[want] = 1'b1;
		end
		assert (io_ack == '0 || io_ack == want_ack) else stop_on_error($sformatf(
			"FAILED t=%0t io_ack: got %b expected %b or none", $time, io_ack, want_ack));
		for (int i = 0; i < `NUM_OF_PU; i++) begin
			due = (cycle - req_cycle[i] == LATENCY);
			if (outstanding[i] && exact_lat[i]) begin
				assert (io_ack[i] == due) else stop_on_error($sformatf(
					"FAILED t=%0t io_ack[%0d]: got %b expected %b", $time, i, io_ack[i], due));
			end
			if (io_ack[i]) begin
				assert (io_ack_data[i] == exp_data[i]) else stop_on_error($sformatf(
					"FAILED t=%0t io_ack_data[%0d]: got %h expected %h",
					$time, i, io_ack_data[i], exp_data[i]));
				outstanding[i] = 1'b0;
				last_winner = pu_id_t'(i);
			end else begin
				assert (io_ack_data[i] == '0) else stop_on_error($sformatf(
					"FAILED t=%0t io_ack_data[%0d]: got %h expected 0", $time, i, io_ack_data[i]));
			end
		end
		io_req = '0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_ms_switch_info = 1'b0;
	endtask

	task automatic wait_all_acks();
		int waited;
		waited = 0;
		while (outstanding != '0 || host_due) begin
			tick();
			waited++;
			assert (waited < TIMEOUT_CYCLES) else
				stop_on_error("timed out waiting for the PU or host acknowledges");
		end
	endtask

	task automatic host_strobe(input logic rd, input row_addr_t row);
		reg_addr = pio_word_t'(row);
		reg_ms_switch_info = 1'b1;
		host_due = 1'b1;
		if (rd) begin
			reg_rd = 1'b1;
			host_due_rd = 1'b1;
			host_exp = model[row];
		end else begin
			reg_din = lcg_next();
			reg_wr = 1'b1;
			model[row] = switch_info_t'(reg_din);
		end
	endtask

	task automatic pu_request(input logic [`NUM_OF_PU-1:0] mask, input io_addr_t addr,
		input fid_t fid, input logic exact);
		io_addr_t a;
		for (int i = 0; i < `NUM_OF_PU; i++) begin
			if (mask[i]) begin
				assert (!outstanding[i]) else
					stop_on_error($sformatf("stimulus requests PU %0d again before its ack", i));
				a = {addr[`IO_ADDR_NBITS-1:`ROW_LOW_NBITS], addr[`ROW_LOW_NBITS-1:0] + 4'(i)};
				io_req[i] = 1'b1;
				io_addr[i] = a; // each PU reads its own row, the low bits are offset by its index
				io_fid[i] = fid;
				if (a[`IO_ADDR_NBITS-1 -: `REGION_NBITS] == `REGION_SWITCH_INFO) begin
					outstanding[i] = 1'b1;
					exp_data[i] = model[{fid, a[`ROW_LOW_NBITS-1:0]}];
					req_cycle[i] = cycle;
					exact_lat[i] = exact;
				end
			end
		end
	endtask

	task automatic add_step(input step_kind_t kind, input logic [`NUM_OF_PU-1:0] mask,
		input io_addr_t addr, input fid_t fid, input logic exact, input logic [7:0] gap,
		input logic sync);
		step_t s;
		s.kind = kind;
		s.mask = mask;
		s.addr = addr;
		s.fid = fid;
		s.exact = exact;
		s.gap = gap;
		s.sync = sync;
		steps.push_back(s);
	endtask

	initial begin
		int waited;
		reg_addr = '0;
		reg_din = '0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_ms_switch_info = 1'b0;
		io_req = '0;
		for (int i = 0; i < `NUM_OF_PU; i++) begin
			io_addr[i] = '0;
			io_fid[i] = '0;
			exp_data[i] = '0;
			req_cycle[i] = 0;
		end
		lcg_state = 32'h0c8396d8;
		outstanding = '0;
		exact_lat = '0;
		last_winner = pu_id_t'(`NUM_OF_PU - 1); // after reset the search starts at PU 0
		host_due = 1'b0;
		host_due_rd = 1'b0;
		host_exp = '0;
		cycle = 0;

		add_step(STEP_HOST_WR, 4'b0000, 16'h0005, 2'd0, 1'b0, 8'd0, 1'b0); // write then read back
		add_step(STEP_HOST_RD, 4'b0000, 16'h0005, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_WR, 4'b0000, 16'h003f, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_RD, 4'b0000, 16'h003f, 2'd0, 1'b0, 8'd0, 1'b1);
		add_step(STEP_PU, 4'b0001, 16'h3007, 2'd1, 1'b1, 8'd0, 1'b1); // single reads, idle host
		add_step(STEP_PU, 4'b0100, 16'h300c, 2'd3, 1'b1, 8'd0, 1'b1);
		add_step(STEP_PU, 4'b1000, 16'h3ff2, 2'd0, 1'b1, 8'd0, 1'b1);
		add_step(STEP_PU, 4'b0010, 16'h5004, 2'd2, 1'b0, 8'd20, 1'b1); // wrong region
		add_step(STEP_PU, 4'b0001, 16'h2004, 2'd1, 1'b0, 8'd20, 1'b1);
		add_step(STEP_PU, 4'b0010, 16'h3001, 2'd0, 1'b1, 8'd0, 1'b1); // moves the pointer to PU 1
		add_step(STEP_PU, 4'b1111, 16'h3009, 2'd1, 1'b0, 8'd0, 1'b1); // all four at once
		add_step(STEP_PU, 4'b1111, 16'h300f, 2'd3, 1'b0, 8'd0, 1'b1);
		add_step(STEP_PU, 4'b1111, 16'h3005, 2'd2, 1'b0, 8'd0, 1'b0); // host strobes while pending
		add_step(STEP_HOST_RD, 4'b0000, 16'h000a, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_WR, 4'b0000, 16'h000b, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_RD, 4'b0000, 16'h000b, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_RD, 4'b0000, 16'h0025, 2'd0, 1'b0, 8'd0, 1'b1);
		add_step(STEP_PU, 4'b1001, 16'h3002, 2'd3, 1'b0, 8'd1, 1'b0); // strobe lands on the grant
		add_step(STEP_HOST_WR, 4'b0000, 16'h000d, 2'd0, 1'b0, 8'd0, 1'b0);
		add_step(STEP_HOST_RD, 4'b0000, 16'h000d, 2'd0, 1'b0, 8'd0, 1'b1);

		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			waited++;
			assert (waited < 50) else stop_on_error("reset was never released");
		end
		for (int r = 0; r < ROWS; r++) begin
			tick(); // first pass also checks the outputs left by reset
			host_strobe(1'b0, row_addr_t'(r));
		end
		foreach (steps[n]) begin
			tick();
			if (steps[n].kind == STEP_PU) begin
				pu_request(steps[n].mask, steps[n].addr, steps[n].fid, steps[n].exact);
			end else begin
				host_strobe(steps[n].kind == STEP_HOST_RD,
					steps[n].addr[`SWITCH_INFO_DEPTH_NBITS-1:0]);
			end
			repeat (steps[n].gap) tick();
			if (steps[n].sync) begin
				wait_all_acks();
			end
		end
		wait_all_acks();
		repeat (5) tick(); // no stray acknowledges afterwards
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
